// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f drum_patch.f \
		--top-module tb_drum_patch -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_drum_patch)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// ==== drum_patch.f ====
+incdir+test
logic/drum_pkg.sv
logic/wb_host_port.sv
logic/node_sequencer.sv
logic/node_update.sv
logic/level_store.sv
logic/drum_patch.sv
test/tb_drum_patch.sv

// ==== logic/drum_patch.sv ====
`timescale 1ns/1ps

module drum_patch #(
	parameter int count_width = 16 // completed step counter
) (
	input logic clock,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [4:0] adr,
	input drum_pkg::sample_t dat_w,
	output drum_pkg::sample_t dat_r,
	output logic ack
);

	logic start;
	logic busy;
	logic rotate;
	drum_pkg::sample_t rho;

	logic host_write;
	drum_pkg::node_t host_index;
	drum_pkg::sample_t host_data;
	drum_pkg::sample_t host_read_data;

	logic issue_valid;
	drum_pkg::node_t issue_index;
	drum_pkg::edge_mask_t issue_edges;

	logic operand_valid;
	drum_pkg::node_t operand_index;
	drum_pkg::sample_t u_center, u_previous;
	drum_pkg::sample_t u_right, u_left, u_up, u_down;

	logic result_valid;
	drum_pkg::node_t result_index;
	drum_pkg::sample_t result_data;

	wb_host_port #(
		.count_width(count_width)
	) host_port_i (
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.busy(busy),
		.rotate(rotate),
		.host_read_data(host_read_data),
		.dat_r(dat_r),
		.ack(ack),
		.start(start),
		.host_write(host_write),
		.host_index(host_index),
		.host_data(host_data),
		.rho(rho)
	);

	// decode: walks the nodes of one step
	node_sequencer sequencer_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.busy(busy),
		.issue_valid(issue_valid),
		.issue_index(issue_index),
		.issue_edges(issue_edges),
		.rotate(rotate)
	);

	// execute: shared node datapath
	node_update update_i (
		.clock(clock),
		.reset(reset),
		.operand_valid(operand_valid),
		.operand_index(operand_index),
		.u_center(u_center),
		.u_previous(u_previous),
		.u_right(u_right),
		.u_left(u_left),
		.u_up(u_up),
		.u_down(u_down),
		.rho(rho),
		.result_valid(result_valid),
		.result_index(result_index),
		.result_data(result_data)
	);

	// result: three rotating grid levels
	level_store store_i (
		.clock(clock),
		.reset(reset),
		.host_write(host_write),
		.host_index(host_index),
		.host_data(host_data),
		.issue_valid(issue_valid),
		.issue_index(issue_index),
		.issue_edges(issue_edges),
		.rotate(rotate),
		.result_valid(result_valid),
		.result_index(result_index),
		.result_data(result_data),
		.host_read_data(host_read_data),
		.operand_valid(operand_valid),
		.operand_index(operand_index),
		.u_center(u_center),
		.u_previous(u_previous),
		.u_right(u_right),
		.u_left(u_left),
		.u_up(u_up),
		.u_down(u_down)
	);

endmodule

// ==== logic/drum_pkg.sv ====
package drum_pkg;

	// node displacement, rho and bus data share one format
	typedef logic signed [17:0] sample_t;

	// row * grid_side + column
	typedef logic [3:0] node_t;

	// 0 to 2, one of the three grid levels
	typedef logic [1:0] level_t;

	// {right, left, up, down}, set where the neighbor exists
	typedef logic [3:0] edge_mask_t;

	localparam int grid_side = 4; // nodes per row
	localparam int node_count = 16;

	// rho is a fraction with this many bits below the point
	localparam int frac_bits = 17;

	// bus addresses above the grid window
	localparam int addr_rho = 16;
	localparam int addr_control = 17;

	// cycles from issue to write-back
	localparam int pipe_depth = 3;

endpackage

// ==== logic/level_store.sv ====
`timescale 1ns/1ps

module level_store (
	input logic clock,
	input logic reset,
	input logic host_write,
	input drum_pkg::node_t host_index,
	input drum_pkg::sample_t host_data,
	input logic issue_valid,
	input drum_pkg::node_t issue_index,
	input drum_pkg::edge_mask_t issue_edges,
	input logic rotate,
	input logic result_valid,
	input drum_pkg::node_t result_index,
	input drum_pkg::sample_t result_data,
	output drum_pkg::sample_t host_read_data,
	output logic operand_valid,
	output drum_pkg::node_t operand_index,
	output drum_pkg::sample_t u_center,
	output drum_pkg::sample_t u_previous,
	output drum_pkg::sample_t u_right,
	output drum_pkg::sample_t u_left,
	output drum_pkg::sample_t u_up,
	output drum_pkg::sample_t u_down
);

	drum_pkg::sample_t grid [3][drum_pkg::node_count];

	drum_pkg::level_t level_ptr; // array holding the current level
	drum_pkg::level_t cur_level, prev_level, next_level;
	drum_pkg::node_t right_index, left_index, up_index, down_index;

	// roles advance by one array per step, nothing is copied
	always_comb begin
		cur_level = level_ptr;
		next_level = (level_ptr == 2'd2) ? 2'd0 : level_ptr + 2'd1;
		prev_level = (level_ptr == 2'd0) ? 2'd2 : level_ptr - 2'd1;
	end

	// wrapped indices are never used, the edge mask drops them
	assign right_index = issue_index + drum_pkg::node_t'(1);
	assign left_index = issue_index - drum_pkg::node_t'(1);
	assign up_index = issue_index - drum_pkg::node_t'(drum_pkg::grid_side);
	assign down_index = issue_index + drum_pkg::node_t'(drum_pkg::grid_side);

	assign host_read_data = grid[cur_level][host_index];

	always_ff @(posedge clock) begin
		if (!reset)
			level_ptr <= '0;
		else if (rotate)
			level_ptr <= next_level; // next becomes current
	end

	always_ff @(posedge clock) begin
		if (host_write) begin
			grid[cur_level][host_index] <= host_data;
			grid[prev_level][host_index] <= '0; // membrane starts at rest
		end
		if (result_valid)
			grid[next_level][result_index] <= result_data;
	end

	always_ff @(posedge clock) begin
		if (!reset)
			operand_valid <= 1'b0;
		else
			operand_valid <= issue_valid;
	end

	always_ff @(posedge clock) begin
		operand_index <= issue_index;
		u_center <= grid[cur_level][issue_index];
		u_previous <= grid[prev_level][issue_index];
		u_right <= issue_edges[3] ? grid[cur_level][right_index] : '0;
		u_left <= issue_edges[2] ? grid[cur_level][left_index] : '0;
		u_up <= issue_edges[1] ? grid[cur_level][up_index] : '0;
		u_down <= issue_edges[0] ? grid[cur_level][down_index] : '0;
	end

endmodule

// ==== logic/node_sequencer.sv ====
`timescale 1ns/1ps

module node_sequencer (
	input logic clock,
	input logic reset,
	input logic start,
	output logic busy,
	output logic issue_valid,
	output drum_pkg::node_t issue_index,
	output drum_pkg::edge_mask_t issue_edges,
	output logic rotate
);

	// sixteen issue cycles, then the pipeline drains
	localparam int last_count = drum_pkg::node_count + drum_pkg::pipe_depth - 1;

	logic [4:0] count;
	logic [1:0] row, col;

	always_ff @(posedge clock) begin
		if (!reset) begin
			busy <= 1'b0;
			count <= '0;
		end else if (start) begin
			busy <= 1'b1;
			count <= '0;
		end else if (busy) begin
			if (count == 5'(last_count))
				busy <= 1'b0; // drain done
			count <= count + 1'b1;
		end
	end

	assign issue_valid = busy && (count < 5'(drum_pkg::node_count));
	assign issue_index = count[3:0];

	assign row = issue_index[3:2];
	assign col = issue_index[1:0];

	// clamped rim: missing neighbors are masked off
	always_comb begin
		issue_edges[3] = col != 2'(drum_pkg::grid_side - 1); // right
		issue_edges[2] = col != 2'd0; // left
		issue_edges[1] = row != 2'd0; // up
		issue_edges[0] = row != 2'(drum_pkg::grid_side - 1); // down
	end

	// last write-back and the level swap share this cycle
	assign rotate = busy && (count == 5'(last_count));

endmodule

// ==== logic/node_update.sv ====
`timescale 1ns/1ps

module node_update (
	input logic clock,
	input logic reset,
	input logic operand_valid,
	input drum_pkg::node_t operand_index,
	input drum_pkg::sample_t u_center,
	input drum_pkg::sample_t u_previous,
	input drum_pkg::sample_t u_right,
	input drum_pkg::sample_t u_left,
	input drum_pkg::sample_t u_up,
	input drum_pkg::sample_t u_down,
	input drum_pkg::sample_t rho,
	output logic result_valid,
	output drum_pkg::node_t result_index,
	output drum_pkg::sample_t result_data
);

	localparam int sample_width = $bits(drum_pkg::sample_t);
	localparam int lap_width = sample_width + 3; // four neighbors minus 4x center
	localparam int prod_width = sample_width + lap_width;

	logic signed [lap_width-1:0] laplacian;
	logic signed [prod_width-1:0] product, product_q;
	logic signed [sample_width+1:0] base, base_q; // 2*center - previous
	logic signed [prod_width-1:0] sum;
	logic stage_valid;
	drum_pkg::node_t stage_index;

	always_comb begin
		laplacian = u_right + u_left + u_up + u_down - (u_center <<< 2);
		product = rho * laplacian; // full width, no rounding
		base = (u_center <<< 1) - u_previous;
	end

	assign sum = (product_q >>> drum_pkg::frac_bits) + base_q;

	always_ff @(posedge clock) begin
		if (!reset) begin
			stage_valid <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			stage_valid <= operand_valid;
			result_valid <= stage_valid;
		end
	end

	always_ff @(posedge clock) begin
		product_q <= product;
		base_q <= base;
		stage_index <= operand_index;
		result_index <= stage_index;
		result_data <= sum[sample_width-1:0]; // wraps to 18 bits
	end

endmodule

// ==== logic/wb_host_port.sv ====
`timescale 1ns/1ps

module wb_host_port #(
	parameter int count_width = 16
) (
	input logic clock,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [4:0] adr,
	input drum_pkg::sample_t dat_w,
	input logic busy,
	input logic rotate,
	input drum_pkg::sample_t host_read_data,
	output drum_pkg::sample_t dat_r,
	output logic ack,
	output logic start,
	output logic host_write,
	output drum_pkg::node_t host_index,
	output drum_pkg::sample_t host_data,
	output drum_pkg::sample_t rho
);

	logic accept;
	logic is_grid, is_rho, is_control;
	logic [count_width-1:0] step_count;
	drum_pkg::sample_t read_data;

	// one access per ack, held off while a step runs
	assign accept = cyc && stb && !ack && !busy;

	assign is_grid = adr < 5'(drum_pkg::node_count);
	assign is_rho = adr == 5'(drum_pkg::addr_rho);
	assign is_control = adr == 5'(drum_pkg::addr_control);

	// grid writes land on the same edge as ack
	assign host_write = accept && we && is_grid;
	assign host_index = adr[3:0];
	assign host_data = dat_w;

	always_comb begin
		if (is_grid)
			read_data = host_read_data;
		else if (is_rho)
			read_data = rho;
		else if (is_control)
			read_data = drum_pkg::sample_t'(step_count); // zero-extended
		else
			read_data = '0; // unmapped
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			ack <= 1'b0;
			start <= 1'b0;
			rho <= '0;
			step_count <= '0;
		end else begin
			ack <= accept;
			start <= accept && we && is_control;
			if (accept && we && is_rho)
				rho <= dat_w;
			if (rotate)
				step_count <= step_count + 1'b1; // one per finished step
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			dat_r <= read_data;
	end

endmodule

// ==== test/drum_model.svh ====
`ifndef drum_model_svh
`define drum_model_svh

drum_pkg::sample_t model_prev [drum_pkg::node_count];
drum_pkg::sample_t model_cur [drum_pkg::node_count];

logic [31:0] lfsr_state = 32'h060e_6d33;

// galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] random_bits(input int count);
	logic [31:0] value;
	value = '0;
	for (int i = 0; i < count; i++) begin
		if (lfsr_state[0])
			lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
		else
			lfsr_state = lfsr_state >> 1;
		value = {value[30:0], lfsr_state[0]}; // one step per bit
	end
	return value;
endfunction

// clamped rim, anything off the patch is zero
function automatic longint neighbor(input int row, input int col);
	if (row < 0 || row >= drum_pkg::grid_side || col < 0 || col >= drum_pkg::grid_side)
		return 0;
	return longint'(model_cur[row * drum_pkg::grid_side + col]);
endfunction

function automatic void model_step(input drum_pkg::sample_t rho);
	drum_pkg::sample_t stepped [drum_pkg::node_count];
	longint center, lap, delta, full;
	int row, col;
	for (int n = 0; n < drum_pkg::node_count; n++) begin
		row = n / drum_pkg::grid_side;
		col = n % drum_pkg::grid_side;
		center = longint'(model_cur[n]);
		lap = neighbor(row, col + 1) + neighbor(row, col - 1) + neighbor(row - 1, col)
			+ neighbor(row + 1, col) - 4 * center;
		delta = (longint'(rho) * lap) >>> drum_pkg::frac_bits;
		full = 2 * center - longint'(model_prev[n]) + delta;
		stepped[n] = drum_pkg::sample_t'(full); // keep the low 18 bits
	end
	model_prev = model_cur;
	model_cur = stepped;
endfunction

`endif

// ==== test/tb_drum_patch.sv ====
`timescale 1ns/1ps

module tb_drum_patch;

	localparam int count_width = 16;
	localparam int wait_limit = 100; // cycles before a bus wait gives up
	localparam int hold_off = drum_pkg::node_count + drum_pkg::pipe_depth + 1;

	logic clock = 1'b0;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [4:0] adr;
	drum_pkg::sample_t dat_w;
	drum_pkg::sample_t dat_r;
	logic ack;

	int cycle_count = 0;
	int last_ack_cycle = 0;
	drum_pkg::sample_t rho;

	`include "drum_model.svh"

	drum_patch #(
		.count_width(count_width)
	) dut_i (
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack)
	);

	always #50 clock = ~clock;

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	task automatic check_sample(input string what, input drum_pkg::sample_t actual,
			input drum_pkg::sample_t expected);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic check_count(input logic [count_width-1:0] actual,
			input logic [count_width-1:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: step count is %0d, expected %0d", $time, actual, expected);
			$display("Simulation failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic check_flag(input string what, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// one classic cycle, signals held until ack
	task automatic wb_cycle(input logic write, input logic [4:0] address,
			input drum_pkg::sample_t data, output drum_pkg::sample_t read_data);
		int waited;
		@(negedge clock);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = address;
		dat_w = data;
		waited = 0;
		while (!ack && waited < wait_limit) begin
			@(negedge clock);
			waited++;
		end
		if (!ack) begin
			$display("no ack for bus address %0d within %0d cycles", address, wait_limit);
			$display("Simulation failed");
			$fatal(1, "bus access timed out");
		end
		read_data = dat_r;
		last_ack_cycle = cycle_count;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic write_word(input logic [4:0] address, input drum_pkg::sample_t data);
		drum_pkg::sample_t unused;
		wb_cycle(1'b1, address, data, unused);
	endtask

	task automatic read_word(input logic [4:0] address, output drum_pkg::sample_t data);
		wb_cycle(1'b0, address, '0, data);
	endtask

	task automatic run_step();
		write_word(5'(drum_pkg::addr_control), '0);
		model_step(rho);
	endtask

	task automatic compare_grid(input string what);
		drum_pkg::sample_t word;
		for (int n = 0; n < drum_pkg::node_count; n++) begin
			read_word(5'(n), word);
			check_sample($sformatf("%s %0d", what, n), word, model_cur[n]);
		end
	endtask

	task automatic compare_steps(input int expected);
		drum_pkg::sample_t word;
		read_word(5'(drum_pkg::addr_control), word);
		check_count(word[count_width-1:0], count_width'(expected));
		check_flag("control read upper bits", |word[17:count_width], 1'b0);
	endtask

	initial begin
		drum_pkg::sample_t word;
		drum_pkg::node_t node;
		int gap;
		reset = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		rho = '0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b1;

		repeat (8) begin
			@(negedge clock);
			check_flag("ack with no request", ack, 1'b0);
		end
		compare_steps(0);

		for (int n = 0; n < drum_pkg::node_count; n++) begin
			word = drum_pkg::sample_t'(random_bits(18));
			write_word(5'(n), word);
			model_prev[n] = '0; // host write also clears previous
			model_cur[n] = word;
		end
		compare_grid("loaded node");

		rho = drum_pkg::sample_t'(random_bits(18));
		write_word(5'(drum_pkg::addr_rho), rho);
		read_word(5'(drum_pkg::addr_rho), word);
		check_sample("rho", word, rho);

		run_step();
		compare_grid("node after one step");
		compare_steps(1);

		repeat (5) begin
			rho = drum_pkg::sample_t'(random_bits(18));
			write_word(5'(drum_pkg::addr_rho), rho);
			run_step();
		end
		compare_grid("node after six steps");
		compare_steps(6);

		// read right behind a start must wait out the whole step
		run_step();
		gap = last_ack_cycle;
		node = drum_pkg::node_t'(random_bits(4));
		read_word(5'(node), word);
		gap = last_ack_cycle - gap;
		check_flag("read held off for the step", gap >= hold_off, 1'b1);
		check_sample("node read behind start", word, model_cur[node]);
		compare_steps(7);

		$display("Simulation passed");
		$finish;
	end

endmodule
